// File: Bender.yml
package:
  name: id_queue

export_include_dirs:
  - .

sources:
  - id_queue_pkg.sv
  - id_queue_free_finder.sv
  - id_queue_head_tail.sv
  - id_queue_linked_data.sv
  - id_queue_ctrl.sv
  - id_queue.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - id_queue_tb.sv

// File: build.f
+incdir+.
id_queue_pkg.sv
id_queue_free_finder.sv
id_queue_head_tail.sv
id_queue_linked_data.sv
id_queue_ctrl.sv
id_queue.sv
tb_clock_gen.sv
id_queue_tb.sv

// File: id_queue.sv
// Top level of the ID queue: control, head-tail table and linked data table
`timescale 1ns/1ps
`default_nettype none

module id_queue (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    input  wire id_queue_pkg::id_t     inp_id_i,
    input  wire id_queue_pkg::data_t   inp_data_i,
    input  wire logic                  inp_req_i,
    output logic                       inp_gnt_o,

    input  wire id_queue_pkg::data_t   exists_data_i,
    input  wire id_queue_pkg::data_t   exists_mask_i,
    input  wire logic                  exists_req_i,
    output logic                       exists_o,
    output logic                       exists_gnt_o,

    input  wire id_queue_pkg::id_t     oup_id_i,
    input  wire logic                  oup_pop_i,
    input  wire logic                  oup_req_i,
    output id_queue_pkg::data_t        oup_data_o,
    output logic                       oup_data_valid_o,
    output logic                       oup_gnt_o
);

    // Operation and lookup ID fan out from the control to both tables
    id_queue_pkg::op_e     op;
    id_queue_pkg::id_t     lookup_id;
    logic                  full;
    logic                  hit;
    id_queue_pkg::data_t   head_data;
    id_queue_pkg::ld_idx_t head_idx;
    id_queue_pkg::ld_idx_t tail_idx;
    id_queue_pkg::ld_idx_t free_idx;
    id_queue_pkg::ld_idx_t head_next;

    id_queue_ctrl u_ctrl (
        .inp_req_i        (inp_req_i),
        .inp_id_i         (inp_id_i),
        .oup_id_i         (oup_id_i),
        .oup_req_i        (oup_req_i),
        .oup_pop_i        (oup_pop_i),
        .full_i           (full),
        .hit_i            (hit),
        .head_data_i      (head_data),
        .op_o             (op),
        .lookup_id_o      (lookup_id),
        .inp_gnt_o        (inp_gnt_o),
        .oup_gnt_o        (oup_gnt_o),
        .oup_data_valid_o (oup_data_valid_o),
        .oup_data_o       (oup_data_o)
    );

    // Head-tail table gets the new cell index and the pop successor from the data table
    id_queue_head_tail u_head_tail (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .op_i        (op),
        .lookup_id_i (lookup_id),
        .free_cell_i (free_idx),
        .head_next_i (head_next),
        .hit_o       (hit),
        .head_idx_o  (head_idx),
        .tail_idx_o  (tail_idx)
    );

    id_queue_linked_data u_linked_data (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .op_i          (op),
        .inp_data_i    (inp_data_i),
        .head_idx_i    (head_idx),
        .tail_idx_i    (tail_idx),
        .exists_data_i (exists_data_i),
        .exists_mask_i (exists_mask_i),
        .exists_req_i  (exists_req_i),
        .full_o        (full),
        .free_idx_o    (free_idx),
        .head_data_o   (head_data),
        .head_next_o   (head_next),
        .exists_o      (exists_o),
        .exists_gnt_o  (exists_gnt_o)
    );

endmodule

`default_nettype wire

// File: id_queue_consts.svh
// Size constants of the ID queue: ID, data and index widths,
// linked data capacity and head-tail capacity
`ifndef ID_QUEUE_CONSTS_SVH
`define ID_QUEUE_CONSTS_SVH

// Bits of an ID, which gives four distinct IDs
`define ID_Q_ID_WIDTH 2

// Number of cells in the linked data table, shared by all IDs
`define ID_Q_CAPACITY 8

// Bits of one stored element
`define ID_Q_DATA_WIDTH 16

// Head-tail entries, the smaller of 2**ID_WIDTH and the capacity
`define ID_Q_HT_CAPACITY 4

// Index widths into the two tables
`define ID_Q_LD_IDX_WIDTH 3
`define ID_Q_HT_IDX_WIDTH 2

`endif

// File: id_queue_ctrl.sv
// Control of the ID queue: operation select, grants,
// lookup ID select and read data gating
`timescale 1ns/1ps
`default_nettype none

module id_queue_ctrl (
    input  wire logic                  inp_req_i,
    input  wire id_queue_pkg::id_t     inp_id_i,
    input  wire id_queue_pkg::id_t     oup_id_i,
    input  wire logic                  oup_req_i,
    input  wire logic                  oup_pop_i,
    input  wire logic                  full_i,
    input  wire logic                  hit_i,
    input  wire id_queue_pkg::data_t   head_data_i,
    output id_queue_pkg::op_e          op_o,
    output id_queue_pkg::id_t          lookup_id_o,
    output logic                       inp_gnt_o,
    output logic                       oup_gnt_o,
    output logic                       oup_data_valid_o,
    output id_queue_pkg::data_t        oup_data_o
);

    logic push_sel;

    // Input wins whenever it can be taken
    assign push_sel  = inp_req_i && !full_i;
    assign inp_gnt_o = push_sel;

    // The tables look up the ID of whichever port is served
    // This depends on requests and full only, so hit has no loop back here
    assign lookup_id_o = push_sel ? inp_id_i : oup_id_i;

    // Output is granted whenever it is not blocked by a push
    assign oup_gnt_o = !push_sel && oup_req_i;

    always_comb begin
        op_o = id_queue_pkg::OP_IDLE;
        if (push_sel) begin
            op_o = hit_i ? id_queue_pkg::OP_PUSH_APPEND : id_queue_pkg::OP_PUSH_NEW;
        end else if (oup_req_i) begin
            if (!hit_i) begin
                op_o = id_queue_pkg::OP_MISS;
            end else if (oup_pop_i) begin
                op_o = id_queue_pkg::OP_POP;
            end else begin
                op_o = id_queue_pkg::OP_PEEK;
            end
        end
    end

    // A miss returns zero data with valid low
    assign oup_data_valid_o = (op_o == id_queue_pkg::OP_PEEK) ||
                              (op_o == id_queue_pkg::OP_POP);
    assign oup_data_o       = oup_data_valid_o ? head_data_i : '0;

endmodule

`default_nettype wire

// File: id_queue_free_finder.sv
// Lowest-index finder over a flag vector, with an any-set flag
`timescale 1ns/1ps
`default_nettype none

module id_queue_free_finder #(
    parameter int WIDTH = 8
) (
    input  wire logic [WIDTH-1:0]                           free_i,
    output logic      [((WIDTH > 1) ? $clog2(WIDTH) : 1)-1:0] idx_o,
    output logic                                            any_o
);

    // Index width, kept at one bit for a single-entry vector
    localparam int IdxWidth = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    // Scan from the top down so the last hit is the lowest set index
    // With no flag set the index stays at zero and any_o tells the caller
    always_comb begin
        idx_o = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (free_i[i]) begin
                idx_o = IdxWidth'(i);
            end
        end
    end

    // Reduction OR tells whether the index above means anything
    assign any_o = |free_i;

endmodule

`default_nettype wire

// File: id_queue_head_tail.sv
// Head-tail table of the ID queue: ID lookup, free entry search
// and head/tail pointer update per operation
`timescale 1ns/1ps
`default_nettype none

`include "id_queue_consts.svh"

module id_queue_head_tail (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire id_queue_pkg::op_e        op_i,
    input  wire id_queue_pkg::id_t        lookup_id_i,
    input  wire id_queue_pkg::ld_idx_t    free_cell_i,
    input  wire id_queue_pkg::ld_idx_t    head_next_i,
    output logic                          hit_o,
    output id_queue_pkg::ld_idx_t         head_idx_o,
    output id_queue_pkg::ld_idx_t         tail_idx_o
);

    // Entry payload, only meaningful while the matching free flag is low
    id_queue_pkg::id_t     ht_id_q   [`ID_Q_HT_CAPACITY];
    id_queue_pkg::ld_idx_t ht_head_q [`ID_Q_HT_CAPACITY];
    id_queue_pkg::ld_idx_t ht_tail_q [`ID_Q_HT_CAPACITY];

    // One free flag per entry, all set after reset
    logic [`ID_Q_HT_CAPACITY-1:0] ht_free_q;

    logic [`ID_Q_HT_CAPACITY-1:0] id_match;
    id_queue_pkg::ht_idx_t        match_idx;
    id_queue_pkg::ht_idx_t        free_entry_idx;
    logic                         any_free;
    logic                         pop_last;

    // An entry matches only while occupied, so stale IDs never hit
    always_comb begin
        for (int i = 0; i < `ID_Q_HT_CAPACITY; i++) begin
            id_match[i] = !ht_free_q[i] && (ht_id_q[i] == lookup_id_i);
        end
    end

    // The match vector is one-hot, so the lowest set bit is the match itself
    id_queue_free_finder #(
        .WIDTH (`ID_Q_HT_CAPACITY)
    ) u_match_finder (
        .free_i (id_match),
        .idx_o  (match_idx),
        .any_o  (hit_o)
    );

    // Lowest free entry, claimed when a new ID arrives
    id_queue_free_finder #(
        .WIDTH (`ID_Q_HT_CAPACITY)
    ) u_free_finder (
        .free_i (ht_free_q),
        .idx_o  (free_entry_idx),
        .any_o  (any_free)
    );

    // Pointers of the matched entry, zero on a miss
    assign head_idx_o = hit_o ? ht_head_q[match_idx] : '0;
    assign tail_idx_o = hit_o ? ht_tail_q[match_idx] : '0;

    // Head equal to tail means the popped cell is the last one of this ID
    assign pop_last = (head_idx_o == tail_idx_o);

    // Free flags carry the occupancy state of the table
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ht_free_q <= '1;
        end else begin
            if (op_i == id_queue_pkg::OP_PUSH_NEW) begin
                ht_free_q[free_entry_idx] <= 1'b0;
            end else if (op_i == id_queue_pkg::OP_POP && pop_last) begin
                ht_free_q[match_idx] <= 1'b1;
            end
        end
    end

    // Entry payload follows the operation of the cycle
    always_ff @(posedge clk_i) begin
        case (op_i)
            id_queue_pkg::OP_PUSH_NEW: begin
                // A new ID starts with a one-cell list
                ht_id_q[free_entry_idx]   <= lookup_id_i;
                ht_head_q[free_entry_idx] <= free_cell_i;
                ht_tail_q[free_entry_idx] <= free_cell_i;
            end
            id_queue_pkg::OP_PUSH_APPEND: begin
                ht_tail_q[match_idx] <= free_cell_i;
            end
            id_queue_pkg::OP_POP: begin
                // The last cell frees the entry, so the head is left as is then
                if (!pop_last) begin
                    ht_head_q[match_idx] <= head_next_i;
                end
            end
            default: begin
            end
        endcase
    end

    // The control only asks for a new entry when one can be claimed
    a_new_has_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
        op_i == id_queue_pkg::OP_PUSH_NEW |-> any_free)
        else $error("New ID pushed while the head-tail table is full");

    // An ID lives in at most one entry across pushes and pops
    a_unique_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(id_match))
        else $error("More than one head-tail entry matches the lookup ID");

endmodule

`default_nettype wire

// File: id_queue_linked_data.sv
// Linked data table of the ID queue: cell storage, free cell search,
// next-pointer chaining and the masked exists search
`timescale 1ns/1ps
`default_nettype none

`include "id_queue_consts.svh"

module id_queue_linked_data (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire id_queue_pkg::op_e        op_i,
    input  wire id_queue_pkg::data_t      inp_data_i,
    input  wire id_queue_pkg::ld_idx_t    head_idx_i,
    input  wire id_queue_pkg::ld_idx_t    tail_idx_i,
    input  wire id_queue_pkg::data_t      exists_data_i,
    input  wire id_queue_pkg::data_t      exists_mask_i,
    input  wire logic                     exists_req_i,
    output logic                          full_o,
    output id_queue_pkg::ld_idx_t         free_idx_o,
    output id_queue_pkg::data_t           head_data_o,
    output id_queue_pkg::ld_idx_t         head_next_o,
    output logic                          exists_o,
    output logic                          exists_gnt_o
);

    // Cell payload and the link to the next cell of the same ID
    id_queue_pkg::data_t   cell_data_q [`ID_Q_CAPACITY];
    id_queue_pkg::ld_idx_t cell_next_q [`ID_Q_CAPACITY];

    // Free flag per cell, all set after reset
    logic [`ID_Q_CAPACITY-1:0] cell_free_q;

    logic [`ID_Q_CAPACITY-1:0] exists_match;
    logic                      any_free;
    logic                      is_push;

    assign is_push = (op_i == id_queue_pkg::OP_PUSH_NEW) ||
                     (op_i == id_queue_pkg::OP_PUSH_APPEND);

    // Lowest free cell receives the next pushed element
    id_queue_free_finder #(
        .WIDTH (`ID_Q_CAPACITY)
    ) u_free_finder (
        .free_i (cell_free_q),
        .idx_o  (free_idx_o),
        .any_o  (any_free)
    );

    // The queue is full exactly when no cell is free
    assign full_o = !any_free;

    // Head cell contents for the output port and the head advance on pop
    assign head_data_o = cell_data_q[head_idx_i];
    assign head_next_o = cell_next_q[head_idx_i];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cell_free_q <= '1;
        end else begin
            if (is_push) begin
                cell_free_q[free_idx_o] <= 1'b0;
            end else if (op_i == id_queue_pkg::OP_POP) begin
                cell_free_q[head_idx_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (is_push) begin
            cell_data_q[free_idx_o] <= inp_data_i;
        end
        // Appending chains the old tail to the new cell
        // The new cell's own link stays unread until something follows it
        if (op_i == id_queue_pkg::OP_PUSH_APPEND) begin
            cell_next_q[tail_idx_i] <= free_idx_o;
        end
    end

    // Compare only the masked bits, and only against occupied cells
    // A zero mask thus matches any occupied cell
    always_comb begin
        for (int i = 0; i < `ID_Q_CAPACITY; i++) begin
            exists_match[i] = !cell_free_q[i] &&
                (((cell_data_q[i] ^ exists_data_i) & exists_mask_i) == '0);
        end
    end

    // The search port is independent and always granted when asked
    assign exists_gnt_o = exists_req_i;
    assign exists_o     = exists_req_i && (|exists_match);

    // The head pointer from the head-tail table must name a live cell
    a_pop_live_cell: assert property (@(posedge clk_i) disable iff (!rst_ni)
        op_i == id_queue_pkg::OP_POP |-> !cell_free_q[head_idx_i])
        else $error("Pop targets a cell that is already free");

endmodule

`default_nettype wire

// File: id_queue_pkg.sv
// Types of the ID queue: ID, element and table index types
// and the enum of the operation served in a cycle
`default_nettype none

`include "id_queue_consts.svh"

package id_queue_pkg;

    // One ID as seen on the input and output ports
    typedef logic [`ID_Q_ID_WIDTH-1:0] id_t;

    // One element, also the shape of the exists data and mask
    typedef logic [`ID_Q_DATA_WIDTH-1:0] data_t;

    // Cell index into the linked data table
    typedef logic [`ID_Q_LD_IDX_WIDTH-1:0] ld_idx_t;

    // Entry index into the head-tail table
    typedef logic [`ID_Q_HT_IDX_WIDTH-1:0] ht_idx_t;

    // Operation chosen by the control for one cycle
    // Only one port is served per cycle, so a single code is enough
    typedef enum logic [2:0] {
        OP_IDLE        = 3'd0,
        OP_PUSH_NEW    = 3'd1,
        OP_PUSH_APPEND = 3'd2,
        OP_PEEK        = 3'd3,
        OP_POP         = 3'd4,
        OP_MISS        = 3'd5
    } op_e;

endpackage

`default_nettype wire

// File: id_queue_tb.sv
// Testbench of the ID queue: vector file reader, stimulus driver,
// output checks and cycle timeout
`timescale 1ns/1ps
`default_nettype none

module id_queue_tb;

    // One cycle of stimulus and expected outputs, without its name
    typedef struct packed {
        logic                inp_req;
        id_queue_pkg::id_t   inp_id;
        id_queue_pkg::data_t inp_data;
        logic                oup_req;
        id_queue_pkg::id_t   oup_id;
        logic                oup_pop;
        logic                exists_req;
        id_queue_pkg::data_t exists_data;
        id_queue_pkg::data_t exists_mask;
        logic                exp_inp_gnt;
        logic                exp_oup_gnt;
        logic                exp_valid;
        id_queue_pkg::data_t exp_data;
        logic                exp_exists;
    } vector_t;

    logic                clk;
    logic                rst_n;
    logic                inp_req;
    id_queue_pkg::id_t   inp_id;
    id_queue_pkg::data_t inp_data;
    logic                inp_gnt;
    logic                exists_req;
    id_queue_pkg::data_t exists_data;
    id_queue_pkg::data_t exists_mask;
    logic                exists;
    logic                exists_gnt;
    logic                oup_req;
    id_queue_pkg::id_t   oup_id;
    logic                oup_pop;
    id_queue_pkg::data_t oup_data;
    logic                oup_data_valid;
    logic                oup_gnt;

    // Vectors and their test names, kept in file order
    vector_t     vecs[$];
    string       names[$];
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;

    tb_clock_gen u_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    id_queue u_id_queue (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .inp_id_i         (inp_id),
        .inp_data_i       (inp_data),
        .inp_req_i        (inp_req),
        .inp_gnt_o        (inp_gnt),
        .exists_data_i    (exists_data),
        .exists_mask_i    (exists_mask),
        .exists_req_i     (exists_req),
        .exists_o         (exists),
        .exists_gnt_o     (exists_gnt),
        .oup_id_i         (oup_id),
        .oup_pop_i        (oup_pop),
        .oup_req_i        (oup_req),
        .oup_data_o       (oup_data),
        .oup_data_valid_o (oup_data_valid),
        .oup_gnt_o        (oup_gnt)
    );

    task automatic check_bit(input string test, input string what,
                             input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: test %s, %s expected %b actual %b", test, what, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "Single-bit output mismatch");
        end
    endtask

    task automatic check_data(input string test, input string what,
                              input id_queue_pkg::data_t exp,
                              input id_queue_pkg::data_t act);
        if (act !== exp) begin
            $display("** Error: test %s, %s expected %h actual %h", test, what, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "Data output mismatch");
        end
    endtask

    // Lines starting with # are column notes, lines with 15 fields are vectors
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] ir, iid, idat, orq, oid, opop, erq, edat, emsk;
        logic [31:0] egi, ego, ev, ed, ee;
        vector_t     v;
        fd = $fopen("id_queue_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file id_queue_tests.txt");
            $display("=== FAIL ===");
            $fatal(1, "Vector file missing");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                name, ir, iid, idat, orq, oid, opop, erq, edat, emsk,
                                egi, ego, ev, ed, ee);
                    if (n == 15) begin
                        v = '{ir[0], iid[1:0], idat[15:0], orq[0], oid[1:0], opop[0],
                              erq[0], edat[15:0], emsk[15:0], egi[0], ego[0], ev[0],
                              ed[15:0], ee[0]};
                        vecs.push_back(v);
                        names.push_back(name);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_vector(input vector_t v);
        inp_req     <= v.inp_req;
        inp_id      <= v.inp_id;
        inp_data    <= v.inp_data;
        oup_req     <= v.oup_req;
        oup_id      <= v.oup_id;
        oup_pop     <= v.oup_pop;
        exists_req  <= v.exists_req;
        exists_data <= v.exists_data;
        exists_mask <= v.exists_mask;
    endtask

    // Outputs are combinational, so the falling edge sees them settled
    // The exists search is granted in every cycle that requests it
    task automatic check_outputs(input string test, input vector_t v);
        check_bit(test, "inp_gnt", v.exp_inp_gnt, inp_gnt);
        check_bit(test, "oup_gnt", v.exp_oup_gnt, oup_gnt);
        check_bit(test, "oup_data_valid", v.exp_valid, oup_data_valid);
        check_data(test, "oup_data", v.exp_data, oup_data);
        check_bit(test, "exists", v.exp_exists, exists);
        check_bit(test, "exists_gnt", v.exists_req, exists_gnt);
    endtask

    // Limit covers reset, one cycle per vector and some slack
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        inp_req     = 1'b0;
        inp_id      = '0;
        inp_data    = '0;
        oup_req     = 1'b0;
        oup_id      = '0;
        oup_pop     = 1'b0;
        exists_req  = 1'b0;
        exists_data = '0;
        exists_mask = '0;
        load_vectors();
        cycle_limit = vecs.size() + 16 + 20;
        wait (rst_n === 1'b1);
        foreach (vecs[i]) begin
            @(posedge clk);
            apply_vector(vecs[i]);
            @(negedge clk);
            check_outputs(names[i], vecs[i]);
        end
        @(posedge clk);
        if (vecs.size() > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("No vectors were read from id_queue_tests.txt");
            $display("=== FAIL ===");
            $fatal(1, "Empty vector file");
        end
    end

endmodule

`default_nettype wire

// File: id_queue_tests.txt
# name ireq iid idata oreq oid pop ereq edata emask | exp: ignt ognt valid data exists
# All values hex, one vector per clock cycle
rst_peek0     0 0 0000 1 0 0 1 0000 0000  0 1 0 0000 0
rst_pop1      0 0 0000 1 1 1 0 0000 0000  0 1 0 0000 0
rst_peek2     0 0 0000 1 2 0 1 ffff ffff  0 1 0 0000 0
rst_pop3      0 0 0000 1 3 1 0 0000 0000  0 1 0 0000 0
push_a0       1 0 a000 0 0 0 0 0000 0000  1 0 0 0000 0
push_b0       1 1 b000 0 0 0 0 0000 0000  1 0 0 0000 0
push_a1       1 0 a001 0 0 0 0 0000 0000  1 0 0 0000 0
push_c0       1 2 c000 0 0 0 0 0000 0000  1 0 0 0000 0
push_d0       1 3 d000 0 0 0 0 0000 0000  1 0 0 0000 0
push_b1       1 1 b001 0 0 0 0 0000 0000  1 0 0 0000 0
peek_b0       0 0 0000 1 1 0 0 0000 0000  0 1 1 b000 0
pop_a0        0 0 0000 1 0 1 0 0000 0000  0 1 1 a000 0
pop_a1        0 0 0000 1 0 1 0 0000 0000  0 1 1 a001 0
pop_b0        0 0 0000 1 1 1 0 0000 0000  0 1 1 b000 0
repush_a      1 0 a100 0 0 0 0 0000 0000  1 0 0 0000 0
fill_c1       1 2 c001 0 0 0 0 0000 0000  1 0 0 0000 0
fill_d1       1 3 d001 0 0 0 0 0000 0000  1 0 0 0000 0
fill_c2       1 2 c002 0 0 0 0 0000 0000  1 0 0 0000 0
fill_d2       1 3 d002 0 0 0 0 0000 0000  1 0 0 0000 0
full_push     1 1 b002 0 0 0 0 0000 0000  0 0 0 0000 0
full_pop      0 0 0000 1 2 1 1 c000 ffff  0 1 1 c000 1
push_vs_pop   1 1 b002 1 2 1 1 c000 ffff  1 0 0 0000 0
pop_b1        0 0 0000 1 1 1 1 b001 ffff  0 1 1 b001 1
pop_b2        0 0 0000 1 1 1 1 b001 ffff  0 1 1 b002 0
peek_c1       0 0 0000 1 2 0 1 c0ff ff00  0 1 1 c001 1
pop_c1        0 0 0000 1 2 1 1 00ff 00ff  0 1 1 c001 0
pop_a100      0 0 0000 1 0 1 1 1234 0000  0 1 1 a100 1
miss_a        0 0 0000 1 0 0 0 0000 0000  0 1 0 0000 0
pop_d0        0 0 0000 1 3 1 0 0000 0000  0 1 1 d000 0
pop_d1        0 0 0000 1 3 1 0 0000 0000  0 1 1 d001 0
pop_d2        0 0 0000 1 3 1 0 0000 0000  0 1 1 d002 0
pop_c2        0 0 0000 1 2 1 0 0000 0000  0 1 1 c002 0
empty_exists  0 0 0000 1 2 0 1 0000 0000  0 1 0 0000 0

// File: tb_clock_gen.sv
// Testbench clock and reset source: 40 ns clock, 16-cycle active-low reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    // Half period of 20 ns gives the 40 ns clock
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Reset is released on a rising edge, like any other driven input
    initial begin
        rst_no = 1'b0;
        repeat (16) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

`default_nettype wire
